//--- hdl/game_settings.svh
`ifndef GAME_SETTINGS_SVH
`define GAME_SETTINGS_SVH

// Playfield size in pixels.
`define SCREEN_W 640
`define SCREEN_H 480

// Target rectangle, a wide and flat ship.
`define TARGET_W 32
`define TARGET_H 16

// Torpedo rectangle, narrow and tall.
`define TORPEDO_W 8
`define TORPEDO_H 16

// Target enters at the left edge near the top of the screen.
`define TARGET_START_X 0
`define TARGET_START_Y 64

// Torpedo waits at the bottom, centred on the playfield.
`define TORPEDO_START_X 316
`define TORPEDO_START_Y 440

// Frame ticks that the result stays on show.
`define END_TIMER_FRAMES 8

`endif

//--- hdl/game_geometry_pkg.sv
package game_geometry_pkg;

    // Top-left corner coordinate.
    // Signed, so a sprite that has left the screen stays representable.
    typedef logic signed [10:0] coord_t;

    // Step per frame on one axis.
    typedef logic signed [5:0] velocity_t;

    // Velocity on both axes.
    typedef struct packed
    {
        velocity_t dx;
        velocity_t dy;
    } velocity_xy_t;

    // Strobes from the master to one sprite engine.
    typedef struct packed
    {
        logic write_xy;
        logic write_dxy;
        logic enable_update;
    } sprite_ctrl_t;

    // Registered position reported by a sprite engine.
    typedef struct packed
    {
        coord_t x;
        coord_t y;
    } sprite_view_t;

endpackage

//--- hdl/game_state_pkg.sv
package game_state_pkg;

    // Round state machine.
    typedef enum logic [2:0]
    {
        START_TARGET,
        WAIT_KEY,
        START_TORPEDO,
        WAIT_COLLISION,
        START_END_TIMER,
        GAME_WON,
        GAME_LOST
    } game_state_t;

    // Playfield status from the overlap detector.
    typedef struct packed
    {
        logic collision;
        logic target_on_screen;
        logic torpedo_on_screen;
    } game_status_t;

endpackage

//--- hdl/game_sprite.sv
module game_sprite
    import game_geometry_pkg::*;
#(
    parameter coord_t START_X = '0,
    parameter coord_t START_Y = '0
)
(
    input  logic         clk,
    input  logic         reset,
    input  logic         frame_tick,
    input  sprite_ctrl_t ctrl,
    input  velocity_xy_t dxy,
    output sprite_view_t view
);

    sprite_view_t pos;
    velocity_xy_t vel;

    // Velocity register.
    // Loaded from the input while the master allows it.
    always_ff @(posedge clk or posedge reset)
    begin
        if (reset)
        begin
            vel <= '0;
        end
        else if (ctrl.write_dxy)
        begin
            vel <= dxy;
        end
    end

    // Position register.
    // A write of the start corner wins over a step.
    always_ff @(posedge clk or posedge reset)
    begin
        if (reset)
        begin
            pos.x <= START_X;
            pos.y <= START_Y;
        end
        else if (ctrl.write_xy)
        begin
            pos.x <= START_X;
            pos.y <= START_Y;
        end
        else if (ctrl.enable_update && frame_tick)
        begin
            // Velocity is sign-extended to the coordinate width.
            pos.x <= pos.x + vel.dx;
            pos.y <= pos.y + vel.dy;
        end
    end

    assign view = pos;

    // The master never restarts a sprite while it is moving it.
    a_no_write_while_moving : assert property
    (
        @(posedge clk) disable iff (reset)
        !(ctrl.write_xy && ctrl.enable_update)
    )
    else
        $error("Sprite write_xy and enable_update high together");

endmodule

//--- hdl/game_overlap.sv
`include "game_settings.svh"

module game_overlap
    import game_geometry_pkg::*;
    import game_state_pkg::*;
#(
    parameter int TARGET_W  = 32,
    parameter int TARGET_H  = 16,
    parameter int TORPEDO_W = 8,
    parameter int TORPEDO_H = 16
)
(
    input  sprite_view_t target,
    input  sprite_view_t torpedo,
    output game_status_t status
);

    // True when the spans [a, a+a_len) and [b, b+b_len) share a pixel.
    function automatic logic spans_meet
    (
        coord_t a,
        int     a_len,
        coord_t b,
        int     b_len
    );
        return (int'(a) < int'(b) + b_len) && (int'(b) < int'(a) + a_len);
    endfunction

    // True when the span [pos, pos+len) lies within [0, limit).
    function automatic logic span_inside
    (
        coord_t pos,
        int     len,
        int     limit
    );
        return (int'(pos) >= 0) && (int'(pos) + len <= limit);
    endfunction

    // Rectangles meet when both axes overlap.
    assign status.collision =
           spans_meet(target.x, TARGET_W, torpedo.x, TORPEDO_W)
        && spans_meet(target.y, TARGET_H, torpedo.y, TORPEDO_H);

    assign status.target_on_screen =
           span_inside(target.x, TARGET_W, `SCREEN_W)
        && span_inside(target.y, TARGET_H, `SCREEN_H);

    assign status.torpedo_on_screen =
           span_inside(torpedo.x, TORPEDO_W, `SCREEN_W)
        && span_inside(torpedo.y, TORPEDO_H, `SCREEN_H);

endmodule

//--- hdl/game_end_timer.sv
`include "game_settings.svh"

module game_end_timer
(
    input  logic clk,
    input  logic reset,
    input  logic frame_tick,
    input  logic start,
    output logic running
);

    localparam int COUNT_W = $clog2(`END_TIMER_FRAMES + 1);

    typedef logic [COUNT_W-1:0] frame_count_t;

    localparam frame_count_t LAST_FRAME = frame_count_t'(`END_TIMER_FRAMES - 1);

    frame_count_t frame_count;

    // Only ticks after the start cycle are counted.
    always_ff @(posedge clk or posedge reset)
    begin
        if (reset)
        begin
            running     <= 1'b0;
            frame_count <= '0;
        end
        else if (start)
        begin
            running     <= 1'b1;
            frame_count <= '0;
        end
        else if (running && frame_tick)
        begin
            if (frame_count == LAST_FRAME)
                running <= 1'b0;
            else
                frame_count <= frame_count + 1'b1;
        end
    end

    a_rise_after_start : assert property
    (
        @(posedge clk) disable iff (reset)
        $rose(running) |-> $past(start)
    )
    else
        $error("End timer started without a start pulse");

endmodule

//--- hdl/game_master_fsm.sv
module game_master_fsm
    import game_geometry_pkg::*;
    import game_state_pkg::*;
(
    input  logic         clk,
    input  logic         reset,
    input  logic         key,
    input  game_status_t status,
    input  logic         timer_running,
    output sprite_ctrl_t target_ctrl,
    output sprite_ctrl_t torpedo_ctrl,
    output logic         timer_start,
    output logic         game_won
);

    game_state_t state;
    game_state_t next_state;
    logic        collision_q;
    logic        end_of_game;

    // Round ends on a hit or when either sprite leaves the playfield.
    assign end_of_game = status.collision
                      || !status.target_on_screen
                      || !status.torpedo_on_screen;

    // Collision seen in the last cycle decides won or lost.
    always_ff @(posedge clk or posedge reset)
    begin
        if (reset)
            collision_q <= 1'b0;
        else
            collision_q <= status.collision;
    end

    always_comb
    begin
        next_state = state;
        unique case (state)
            START_TARGET:
                next_state = WAIT_KEY;
            WAIT_KEY:
            begin
                // Firing takes priority over the end of the round.
                if (key)
                    next_state = START_TORPEDO;
                else if (end_of_game)
                    next_state = START_END_TIMER;
            end
            START_TORPEDO:
                next_state = WAIT_COLLISION;
            WAIT_COLLISION:
            begin
                if (end_of_game)
                    next_state = START_END_TIMER;
            end
            START_END_TIMER:
                next_state = collision_q ? GAME_WON : GAME_LOST;
            GAME_WON, GAME_LOST:
            begin
                if (!timer_running)
                    next_state = START_TARGET;
            end
            default:
                next_state = START_TARGET;
        endcase
    end

    always_ff @(posedge clk or posedge reset)
    begin
        if (reset)
            state <= START_TARGET;
        else
            state <= next_state;
    end

    // Strobes come from the state alone.
    assign target_ctrl.write_xy       = (state == START_TARGET);
    assign target_ctrl.write_dxy      = (state == START_TARGET);
    assign target_ctrl.enable_update  = (state == WAIT_KEY) || (state == WAIT_COLLISION);

    // Torpedo aim stays live in flight.
    assign torpedo_ctrl.write_xy      = (state == START_TARGET);
    assign torpedo_ctrl.write_dxy     = (state == WAIT_KEY) || (state == WAIT_COLLISION);
    assign torpedo_ctrl.enable_update = (state == WAIT_COLLISION);

    assign timer_start = (state == START_END_TIMER);
    assign game_won    = (state == GAME_WON);

    a_timer_start_pulse : assert property
    (
        @(posedge clk) disable iff (reset)
        timer_start |=> !timer_start
    )
    else
        $error("timer_start longer than one cycle");

    // The timer is already running when the win is shown.
    a_won_with_timer : assert property
    (
        @(posedge clk) disable iff (reset)
        $rose(game_won) |-> timer_running
    )
    else
        $error("game_won rose while the end timer was idle");

endmodule

//--- hdl/game_top.sv
`include "game_settings.svh"

module game_top
    import game_geometry_pkg::*;
    import game_state_pkg::*;
(
    input  logic         clk,
    input  logic         reset,
    input  logic         key,
    input  logic         frame_tick,
    input  velocity_xy_t target_dxy,
    input  velocity_xy_t torpedo_dxy,
    output sprite_view_t target_view,
    output sprite_view_t torpedo_view,
    output logic         collision,
    output logic         game_won,
    output logic         end_timer_running
);

    sprite_ctrl_t target_ctrl;
    sprite_ctrl_t torpedo_ctrl;
    game_status_t status;
    logic         timer_start;

    game_sprite
    #(
        .START_X ( `TARGET_START_X ),
        .START_Y ( `TARGET_START_Y )
    )
    target_i
    (
        .clk        ( clk          ),
        .reset      ( reset        ),
        .frame_tick ( frame_tick   ),
        .ctrl       ( target_ctrl  ),
        .dxy        ( target_dxy   ),
        .view       ( target_view  )
    );

    game_sprite
    #(
        .START_X ( `TORPEDO_START_X ),
        .START_Y ( `TORPEDO_START_Y )
    )
    torpedo_i
    (
        .clk        ( clk          ),
        .reset      ( reset        ),
        .frame_tick ( frame_tick   ),
        .ctrl       ( torpedo_ctrl ),
        .dxy        ( torpedo_dxy  ),
        .view       ( torpedo_view )
    );

    game_overlap
    #(
        .TARGET_W  ( `TARGET_W  ),
        .TARGET_H  ( `TARGET_H  ),
        .TORPEDO_W ( `TORPEDO_W ),
        .TORPEDO_H ( `TORPEDO_H )
    )
    overlap_i
    (
        .target  ( target_view  ),
        .torpedo ( torpedo_view ),
        .status  ( status       )
    );

    game_master_fsm master_i
    (
        .clk           ( clk               ),
        .reset         ( reset             ),
        .key           ( key               ),
        .status        ( status            ),
        .timer_running ( end_timer_running ),
        .target_ctrl   ( target_ctrl       ),
        .torpedo_ctrl  ( torpedo_ctrl      ),
        .timer_start   ( timer_start       ),
        .game_won      ( game_won          )
    );

    game_end_timer end_timer_i
    (
        .clk        ( clk               ),
        .reset      ( reset             ),
        .frame_tick ( frame_tick        ),
        .start      ( timer_start       ),
        .running    ( end_timer_running )
    );

    assign collision = status.collision;

endmodule

//--- tests/game_tb.sv
`include "game_settings.svh"

module game_tb
    import game_geometry_pkg::*;
    import game_state_pkg::*;
;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int NUM_ROUNDS   = 23;
    // Slowest drift leaves the screen after about 610 cycles, plus the end timer.
    localparam int ROUND_CYCLES = 700;
    localparam int CYCLE_LIMIT  = NUM_ROUNDS * ROUND_CYCLES + 50;

    // Everything the reference model tracks from one clock to the next.
    typedef struct packed
    {
        sprite_view_t target;
        sprite_view_t torpedo;
        velocity_xy_t target_vel;
        velocity_xy_t torpedo_vel;
        game_state_t  state;
        logic         hit_last;
        logic         timer_on;
        logic [7:0]   timer_ticks;
    } model_t;

    logic         clk;
    logic         reset;
    logic         key;
    logic         frame_tick;
    velocity_xy_t target_dxy;
    velocity_xy_t torpedo_dxy;
    sprite_view_t target_view;
    sprite_view_t torpedo_view;
    logic         collision;
    logic         game_won;
    logic         end_timer_running;

    model_t model;
    int     seed;
    int     tick_phase;
    int     cycle_count;
    int     mismatch_count;
    int     other_count;

    game_top dut_i
    (
        .clk               ( clk               ),
        .reset             ( reset             ),
        .key               ( key               ),
        .frame_tick        ( frame_tick        ),
        .target_dxy        ( target_dxy        ),
        .torpedo_dxy       ( torpedo_dxy       ),
        .target_view       ( target_view       ),
        .torpedo_view      ( torpedo_view      ),
        .collision         ( collision         ),
        .game_won          ( game_won          ),
        .end_timer_running ( end_timer_running )
    );

    function automatic velocity_xy_t make_velocity(int dx, int dy);
        velocity_xy_t v;
        v.dx = velocity_t'(dx);
        v.dy = velocity_t'(dy);
        return v;
    endfunction

    function automatic sprite_view_t corner(int x, int y);
        sprite_view_t c;
        c.x = coord_t'(x);
        c.y = coord_t'(y);
        return c;
    endfunction

    // Rectangles touch unless one lies fully to a side of the other.
    function automatic logic rects_touch(sprite_view_t a, int aw, int ah,
                                         sprite_view_t b, int bw, int bh);
        int ax;
        int ay;
        int bx;
        int by;
        ax = a.x;
        ay = a.y;
        bx = b.x;
        by = b.y;
        return !(ax + aw <= bx || bx + bw <= ax || ay + ah <= by || by + bh <= ay);
    endfunction

    function automatic logic fits_screen(sprite_view_t s, int w, int h);
        int sx;
        int sy;
        sx = s.x;
        sy = s.y;
        return sx >= 0 && sy >= 0 && sx + w <= `SCREEN_W && sy + h <= `SCREEN_H;
    endfunction

    function automatic logic model_hit(model_t m);
        return rects_touch(m.target, `TARGET_W, `TARGET_H,
                           m.torpedo, `TORPEDO_W, `TORPEDO_H);
    endfunction

    function automatic model_t reset_model();
        model_t m;
        m             = '0;
        m.target      = corner(`TARGET_START_X, `TARGET_START_Y);
        m.torpedo     = corner(`TORPEDO_START_X, `TORPEDO_START_Y);
        m.state       = START_TARGET;
        return m;
    endfunction

    // One clock of the game, from the old model and this cycle's inputs.
    function automatic model_t step_model(model_t m, logic key_in, logic tick,
                                          velocity_xy_t t_dxy, velocity_xy_t p_dxy);
        model_t n;
        logic   hit;
        logic   over;
        n    = m;
        hit  = model_hit(m);
        over = hit || !fits_screen(m.target, `TARGET_W, `TARGET_H)
                   || !fits_screen(m.torpedo, `TORPEDO_W, `TORPEDO_H);
        n.hit_last = hit;

        if (m.state == START_TARGET)
        begin
            n.target     = corner(`TARGET_START_X, `TARGET_START_Y);
            n.torpedo    = corner(`TORPEDO_START_X, `TORPEDO_START_Y);
            n.target_vel = t_dxy;
        end
        if (m.state == WAIT_KEY || m.state == WAIT_COLLISION)
        begin
            n.torpedo_vel = p_dxy;
            if (tick)
            begin
                n.target.x = m.target.x + m.target_vel.dx;
                n.target.y = m.target.y + m.target_vel.dy;
            end
        end
        if (m.state == WAIT_COLLISION && tick)
        begin
            n.torpedo.x = m.torpedo.x + m.torpedo_vel.dx;
            n.torpedo.y = m.torpedo.y + m.torpedo_vel.dy;
        end

        // Timer drops after the last counted tick following the start.
        if (m.state == START_END_TIMER)
        begin
            n.timer_on    = 1'b1;
            n.timer_ticks = '0;
        end
        else if (m.timer_on && tick)
        begin
            n.timer_ticks = m.timer_ticks + 1'b1;
            if (n.timer_ticks == `END_TIMER_FRAMES)
                n.timer_on = 1'b0;
        end

        case (m.state)
            START_TARGET:    n.state = WAIT_KEY;
            WAIT_KEY:
            begin
                if (key_in)
                    n.state = START_TORPEDO;
                else if (over)
                    n.state = START_END_TIMER;
            end
            START_TORPEDO:   n.state = WAIT_COLLISION;
            WAIT_COLLISION:
            begin
                if (over)
                    n.state = START_END_TIMER;
            end
            START_END_TIMER: n.state = m.hit_last ? GAME_WON : GAME_LOST;
            default:
            begin
                if (!m.timer_on)
                    n.state = START_TARGET;
            end
        endcase
        return n;
    endfunction

    task automatic compare_view(string name, sprite_view_t got, sprite_view_t exp);
        if (got !== exp)
        begin
            $display("MISMATCH at %0t: %s got %0d,%0d expected %0d,%0d",
                     $time, name, got.x, got.y, exp.x, exp.y);
            mismatch_count++;
        end
    endtask

    task automatic compare_bit(string name, logic got, logic exp);
        if (got !== exp)
        begin
            $display("MISMATCH at %0t: %s got %b expected %b", $time, name, got, exp);
            mismatch_count++;
        end
    endtask

    task automatic next_cycle();
        @(posedge clk);
        #10;
    endtask

    // One round from WAIT_KEY until the sprites are back at their corners.
    // A negative key_cycles never fires, a negative expect_won is not checked.
    task automatic play_round(velocity_xy_t aim, int key_cycles, velocity_xy_t steer,
                              int steer_cycles, velocity_xy_t next_drift, int expect_won);
        torpedo_dxy = aim;
        if (key_cycles >= 0)
        begin
            repeat (key_cycles) next_cycle();
            key = 1'b1;
            next_cycle();
            key = 1'b0;
        end
        if (steer_cycles > 0)
        begin
            repeat (steer_cycles) next_cycle();
            torpedo_dxy = steer;
        end
        while (!end_timer_running)
            next_cycle();
        if (expect_won >= 0)
            compare_bit("game_won", game_won, expect_won[0]);
        // Drift for the next round is loaded when the master restarts.
        target_dxy = next_drift;
        while (end_timer_running)
            next_cycle();
        repeat (2) next_cycle();
        compare_view("target_view", target_view, corner(`TARGET_START_X, `TARGET_START_Y));
        compare_view("torpedo_view", torpedo_view, corner(`TORPEDO_START_X, `TORPEDO_START_Y));
    endtask

    always #50 clk = ~clk;

    // Frame tick every fourth cycle.
    always @(posedge clk)
    begin
        #10;
        frame_tick = (tick_phase == 3);
        tick_phase = (tick_phase + 1) % 4;
    end

    always @(posedge clk)
    begin
        if (reset)
            model = reset_model();
        else
            model = step_model(model, key, frame_tick, target_dxy, torpedo_dxy);
    end

    always @(negedge clk)
    begin
        if (!reset)
        begin
            compare_view("target_view", target_view, model.target);
            compare_view("torpedo_view", torpedo_view, model.torpedo);
            compare_bit("collision", collision, model_hit(model));
            compare_bit("game_won", game_won, model.state == GAME_WON);
            compare_bit("end_timer_running", end_timer_running, model.timer_on);
        end
    end

    always @(posedge clk)
    begin
        cycle_count++;
        if (cycle_count >= CYCLE_LIMIT)
        begin
            $display("Timeout: rounds did not finish within %0d cycles", CYCLE_LIMIT);
            other_count++;
            $display("Errors: %0d mismatches, %0d other", mismatch_count, other_count);
            $display("*** FAILED ***");
            $finish;
        end
    end

    initial
    begin
        velocity_xy_t aim;
        velocity_xy_t drift;
        int           delay;
        clk            = 1'b0;
        reset          = 1'b1;
        key            = 1'b0;
        frame_tick     = 1'b0;
        tick_phase     = 0;
        cycle_count    = 0;
        mismatch_count = 0;
        other_count    = 0;
        seed           = 98;
        model          = reset_model();
        target_dxy     = make_velocity(4, 0);
        torpedo_dxy    = make_velocity(0, 0);

        repeat (3) @(posedge clk);
        #10;
        reset = 1'b0;
        compare_view("target_view", target_view, corner(`TARGET_START_X, `TARGET_START_Y));
        compare_view("torpedo_view", torpedo_view, corner(`TORPEDO_START_X, `TORPEDO_START_Y));
        compare_bit("game_won", game_won, 1'b0);
        compare_bit("end_timer_running", end_timer_running, 1'b0);
        next_cycle();

        // Late launch meets the slow target near the middle of the screen.
        play_round(make_velocity(0, -16), 210, make_velocity(0, 0), 0,
                   make_velocity(6, 0), 1);
        // Early launch misses, is steered in flight and leaves at the top.
        play_round(make_velocity(0, -16), 3, make_velocity(8, -16), 40,
                   make_velocity(20, 1), 0);

        drift = make_velocity(4 + ($unsigned($random(seed)) % 8),
                              int'($unsigned($random(seed)) % 5) - 2);
        // Fast target drifts off with no key.
        play_round(make_velocity(0, -16), -1, make_velocity(0, 0), 0, drift, 0);

        for (int i = 0; i < NUM_ROUNDS - 3; i++)
        begin
            aim   = make_velocity(int'($unsigned($random(seed)) % 9) - 4,
                                  -8 - int'($unsigned($random(seed)) % 9));
            delay = 3 + ($unsigned($random(seed)) % 58);
            drift = make_velocity(4 + ($unsigned($random(seed)) % 8),
                                  int'($unsigned($random(seed)) % 5) - 2);
            play_round(aim, delay, make_velocity(0, 0), 0, drift, -1);
        end

        $display("Errors: %0d mismatches, %0d other", mismatch_count, other_count);
        if (mismatch_count + other_count == 0)
            $display("*** PASSED ***");
        else
            $display("*** FAILED ***");
        $finish;
    end

endmodule

//--- game.f
+incdir+hdl
hdl/game_geometry_pkg.sv
hdl/game_state_pkg.sv
hdl/game_sprite.sv
hdl/game_overlap.sv
hdl/game_end_timer.sv
hdl/game_master_fsm.sv
hdl/game_top.sv
tests/game_tb.sv

//--- Bender.yml
package:
  name: game

sources:
  - include_dirs:
      - hdl
    files:
      - hdl/game_geometry_pkg.sv
      - hdl/game_state_pkg.sv
      - hdl/game_sprite.sv
      - hdl/game_overlap.sv
      - hdl/game_end_timer.sv
      - hdl/game_master_fsm.sv
      - hdl/game_top.sv
  - target: test
    include_dirs:
      - hdl
    files:
      - tests/game_tb.sv
